//--- src/cache_pkg.sv
package cache_pkg;

  // cache geometry
  localparam int SETS        = 8;
  localparam int WAYS        = 2;
  localparam int BLOCK_WORDS = 2;

  // main memory, decoded on address bits 9 to 2
  localparam int MEM_WORDS   = 256;
  localparam int MEM_LATENCY = 3;

  // data word or byte address
  typedef logic [31:0] word_t;

  // address bits 31 to 6
  typedef logic [25:0] tag_t;

  // address bits 5 to 3
  typedef logic [2:0] idx_t;

endpackage

//--- src/dcache.sv
`timescale 1ns/1ns

module dcache (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             dmem_ren,
  input  logic             dmem_wen,
  input  logic             halt,
  input  cache_pkg::word_t dmem_addr,
  input  cache_pkg::word_t dmem_store,
  output logic             dhit,
  output logic             flushed,
  output cache_pkg::word_t dmem_load,
  input  logic             mem_wait,
  input  cache_pkg::word_t mem_load,
  output logic             mem_ren,
  output logic             mem_wen,
  output cache_pkg::word_t mem_addr,
  output cache_pkg::word_t mem_store
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_WB0,
    S_WB1,
    S_FILL0,
    S_FILL1,
    S_HSCAN,
    S_HWB0,
    S_HWB1,
    S_FLUSHED
  } state_t;

  state_t state;
  state_t next_state;

  // line tables
  logic             valid [cache_pkg::WAYS][cache_pkg::SETS];
  logic             dirty [cache_pkg::WAYS][cache_pkg::SETS];
  cache_pkg::tag_t  tags  [cache_pkg::WAYS][cache_pkg::SETS];
  cache_pkg::word_t data  [cache_pkg::WAYS][cache_pkg::SETS][cache_pkg::BLOCK_WORDS];

  // way to evict next in each set
  logic             lru [cache_pkg::SETS];

  // request fields
  cache_pkg::tag_t  req_tag;
  cache_pkg::idx_t  req_idx;
  logic             req_blk;
  logic             req;

  logic             hit0;
  logic             hit1;
  logic             hit;
  logic             hit_way;
  logic             victim;
  cache_pkg::tag_t  vic_tag;

  // halt scan pointer
  cache_pkg::idx_t  h_set;
  logic             h_way;
  logic             scan_last;

  // table update strobes
  logic             hit_upd;
  logic             store_hit;
  logic             wb_done;
  logic             fill0_done;
  logic             fill1_done;
  logic             hwb_done;
  logic             scan_step;
  logic             scan_end;

  assign req_tag = dmem_addr[31:6];
  assign req_idx = dmem_addr[5:3];
  assign req_blk = dmem_addr[2];
  assign req     = dmem_ren | dmem_wen;

  assign hit0    = valid[0][req_idx] && (tags[0][req_idx] == req_tag);
  assign hit1    = valid[1][req_idx] && (tags[1][req_idx] == req_tag);
  assign hit     = hit0 | hit1;
  assign hit_way = hit1;

  assign victim  = lru[req_idx];
  assign vic_tag = tags[victim][req_idx];

  assign dmem_load = data[hit_way][req_idx][req_blk];

  assign scan_last = h_way && (h_set == cache_pkg::idx_t'(cache_pkg::SETS - 1));

  assign hit_upd    = (state == S_IDLE) && req && hit;
  assign store_hit  = hit_upd && dmem_wen;
  assign wb_done    = (state == S_WB1) && !mem_wait;
  assign fill0_done = (state == S_FILL0) && !mem_wait;
  assign fill1_done = (state == S_FILL1) && !mem_wait;
  assign hwb_done   = (state == S_HWB1) && !mem_wait;
  assign scan_step  = (state == S_HSCAN) && !dirty[h_way][h_set];
  assign scan_end   = scan_step && scan_last;

  always_comb begin
    next_state = state;
    dhit       = 1'b0;
    flushed    = 1'b0;
    mem_ren    = 1'b0;
    mem_wen    = 1'b0;
    mem_addr   = '0;
    mem_store  = '0;
    case (state)
      S_IDLE: begin
        if (req && hit) begin
          dhit = 1'b1;
        end else if (req) begin
          // dirty victim goes out before the refill
          next_state = dirty[victim][req_idx] ? S_WB0 : S_FILL0;
        end else if (halt) begin
          next_state = S_HSCAN;
        end
      end
      S_WB0: begin
        mem_wen   = 1'b1;
        mem_addr  = {vic_tag, req_idx, 1'b0, 2'b00};
        mem_store = data[victim][req_idx][0];
        if (!mem_wait) begin
          next_state = S_WB1;
        end
      end
      S_WB1: begin
        mem_wen   = 1'b1;
        mem_addr  = {vic_tag, req_idx, 1'b1, 2'b00};
        mem_store = data[victim][req_idx][1];
        if (!mem_wait) begin
          next_state = S_FILL0;
        end
      end
      S_FILL0: begin
        mem_ren  = 1'b1;
        mem_addr = {req_tag, req_idx, 1'b0, 2'b00};
        if (!mem_wait) begin
          next_state = S_FILL1;
        end
      end
      S_FILL1: begin
        mem_ren  = 1'b1;
        mem_addr = {req_tag, req_idx, 1'b1, 2'b00};
        // request is served as a hit on return to idle
        if (!mem_wait) begin
          next_state = S_IDLE;
        end
      end
      S_HSCAN: begin
        if (dirty[h_way][h_set]) begin
          next_state = S_HWB0;
        end else if (scan_last) begin
          next_state = S_FLUSHED;
        end
      end
      S_HWB0: begin
        mem_wen   = 1'b1;
        mem_addr  = {tags[h_way][h_set], h_set, 1'b0, 2'b00};
        mem_store = data[h_way][h_set][0];
        if (!mem_wait) begin
          next_state = S_HWB1;
        end
      end
      S_HWB1: begin
        mem_wen   = 1'b1;
        mem_addr  = {tags[h_way][h_set], h_set, 1'b1, 2'b00};
        mem_store = data[h_way][h_set][1];
        // back to scan, which now sees the line clean
        if (!mem_wait) begin
          next_state = S_HSCAN;
        end
      end
      S_FLUSHED: begin
        flushed = 1'b1;
        if (!halt) begin
          next_state = S_IDLE;
        end
      end
      default: begin
        next_state = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      state <= S_IDLE;
      h_set <= '0;
      h_way <= 1'b0;
      for (int s = 0; s < cache_pkg::SETS; s++) begin
        lru[s] <= 1'b0;
        for (int w = 0; w < cache_pkg::WAYS; w++) begin
          valid[w][s] <= 1'b0;
          dirty[w][s] <= 1'b0;
        end
      end
    end else begin
      state <= next_state;

      if (hit_upd) begin
        lru[req_idx] <= ~hit_way;
        if (dmem_wen) begin
          dirty[hit_way][req_idx] <= 1'b1;
        end
      end

      if (wb_done) begin
        dirty[victim][req_idx] <= 1'b0;
      end

      // line is unusable while half filled
      if (fill0_done) begin
        valid[victim][req_idx] <= 1'b0;
      end
      if (fill1_done) begin
        valid[victim][req_idx] <= 1'b1;
      end

      if ((state == S_IDLE) && (next_state == S_HSCAN)) begin
        h_set <= '0;
        h_way <= 1'b0;
      end

      if (scan_step) begin
        h_way <= ~h_way;
        if (h_way) begin
          h_set <= h_set + 1'b1;
        end
      end

      if (hwb_done) begin
        dirty[h_way][h_set] <= 1'b0;
      end

      // everything written back, empty the cache
      if (scan_end) begin
        for (int s = 0; s < cache_pkg::SETS; s++) begin
          lru[s] <= 1'b0;
          for (int w = 0; w < cache_pkg::WAYS; w++) begin
            valid[w][s] <= 1'b0;
            dirty[w][s] <= 1'b0;
          end
        end
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (store_hit) begin
      data[hit_way][req_idx][req_blk] <= dmem_store;
    end
    if (fill0_done) begin
      data[victim][req_idx][0] <= mem_load;
    end
    if (fill1_done) begin
      data[victim][req_idx][1] <= mem_load;
      tags[victim][req_idx]    <= req_tag;
    end
  end

endmodule

//--- src/main_mem.sv
`timescale 1ns/1ns

module main_mem (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             mem_ren,
  input  logic             mem_wen,
  input  cache_pkg::word_t mem_addr,
  input  cache_pkg::word_t mem_store,
  output logic             mem_wait,
  output cache_pkg::word_t mem_load
);

  cache_pkg::word_t mem [cache_pkg::MEM_WORDS];

  logic [$clog2(cache_pkg::MEM_WORDS) - 1:0]       widx;
  logic [$clog2(cache_pkg::MEM_LATENCY + 1) - 1:0] cnt;

  // request seen last cycle
  logic             held;
  logic             held_ren;
  logic             held_wen;
  cache_pkg::word_t held_addr;

  logic             req;
  logic             same_req;

  // byte address to word index, upper bits ignored
  assign widx = mem_addr[$clog2(cache_pkg::MEM_WORDS) + 1:2];
  assign req  = mem_ren | mem_wen;

  assign same_req = held && (mem_addr == held_addr) &&
                    (mem_ren == held_ren) && (mem_wen == held_wen);

  assign mem_wait = req && !(same_req && (cnt == $bits(cnt)'(cache_pkg::MEM_LATENCY)));
  assign mem_load = mem[widx];

  always_ff @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      held      <= 1'b0;
      held_ren  <= 1'b0;
      held_wen  <= 1'b0;
      held_addr <= '0;
      cnt       <= '0;
      for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (!req) begin
      held <= 1'b0;
      cnt  <= '0;
    end else if (!mem_wait) begin
      // transfer done, the next one waits again
      held <= 1'b0;
      cnt  <= '0;
      if (mem_wen) begin
        mem[widx] <= mem_store;
      end
    end else if (!same_req) begin
      held      <= 1'b1;
      held_ren  <= mem_ren;
      held_wen  <= mem_wen;
      held_addr <= mem_addr;
      cnt       <= $bits(cnt)'(1);
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             dmem_ren,
  input  logic             dmem_wen,
  input  cache_pkg::word_t dmem_addr,
  input  cache_pkg::word_t dmem_store,
  input  logic             halt,
  output logic             dhit,
  output cache_pkg::word_t dmem_load,
  output logic             flushed
);

  // cache to memory
  logic             mem_ren;
  logic             mem_wen;
  logic             mem_wait;
  cache_pkg::word_t mem_addr;
  cache_pkg::word_t mem_store;
  cache_pkg::word_t mem_load;

  dcache u_dcache (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .halt       (halt),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dhit       (dhit),
    .flushed    (flushed),
    .dmem_load  (dmem_load),
    .mem_wait   (mem_wait),
    .mem_load   (mem_load),
    .mem_ren    (mem_ren),
    .mem_wen    (mem_wen),
    .mem_addr   (mem_addr),
    .mem_store  (mem_store)
  );

  main_mem u_main_mem (
    .CLK       (CLK),
    .nRST      (nRST),
    .mem_ren   (mem_ren),
    .mem_wen   (mem_wen),
    .mem_addr  (mem_addr),
    .mem_store (mem_store),
    .mem_wait  (mem_wait),
    .mem_load  (mem_load)
  );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
  output logic CLK
);

  localparam int HALF_PERIOD = 20;

  initial begin
    CLK = 1'b0;
    forever begin
      #(HALF_PERIOD) CLK = ~CLK;
    end
  end

endmodule

//--- bench/dcache_tb.sv
`timescale 1ns/1ns

module dcache_tb;

  localparam int          TIMEOUT_CYCLES = 500;
  localparam int          RANDOM_OPS     = 200;
  localparam int          AW             = $clog2(cache_pkg::MEM_WORDS);
  localparam logic [31:0] SEED           = 32'h48c4539c;

  logic             CLK;
  logic             nRST;
  logic             dmem_ren;
  logic             dmem_wen;
  logic             halt;
  cache_pkg::word_t dmem_addr;
  cache_pkg::word_t dmem_store;
  logic             dhit;
  logic             flushed;
  cache_pkg::word_t dmem_load;

  // reference memory and the words stored so far
  cache_pkg::word_t ref_mem [cache_pkg::MEM_WORDS];
  logic             touched [cache_pkg::MEM_WORDS];

  int               checks;
  int               errors;
  int               timeouts;
  logic [31:0]      rng;

  tb_clock clk_gen (.CLK(CLK));

  dcache_top UUT (
    .CLK        (CLK),
    .nRST       (nRST),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .halt       (halt),
    .dhit       (dhit),
    .dmem_load  (dmem_load),
    .flushed    (flushed)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // tag in bits 9 to 6 keeps the address inside memory
  function automatic cache_pkg::word_t make_addr(input int tag, input int set, input int blk);
    return cache_pkg::word_t'((tag << 6) | (set << 3) | (blk << 2));
  endfunction

  function automatic cache_pkg::word_t expected_load(input cache_pkg::word_t addr);
    return ref_mem[addr[AW+1:2]];
  endfunction

  task automatic check_word(input string name, input cache_pkg::word_t exp,
                            input cache_pkg::word_t got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, got %h", name, exp, got);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: expected %h, got %h", name, exp, got);
    end
  endtask

  // present one request and hold it until dhit is seen before a rising edge
  task automatic access(input logic write, input cache_pkg::word_t addr,
                        input cache_pkg::word_t wdata, output cache_pkg::word_t rdata,
                        output logic quick);
    int cycles;
    rdata = '0;
    quick = 1'b0;
    if (timeouts == 0) begin
      @(negedge CLK);
      dmem_ren   = !write;
      dmem_wen   = write;
      dmem_addr  = addr;
      dmem_store = wdata;
      #1;
      quick  = dhit;
      cycles = 0;
      while (dhit !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
        @(negedge CLK);
        #1;
        cycles++;
      end
      if (dhit !== 1'b1) begin
        timeouts++;
        $display("timeout: no dhit for address %h within %0d cycles", addr, TIMEOUT_CYCLES);
      end else begin
        rdata = dmem_load;
        @(posedge CLK);
      end
    end
  endtask

  task automatic store_word(input cache_pkg::word_t addr, input cache_pkg::word_t data);
    cache_pkg::word_t unused;
    logic             quick;
    access(1'b1, addr, data, unused, quick);
    ref_mem[addr[AW+1:2]] = data;
    touched[addr[AW+1:2]] = 1'b1;
  endtask

  task automatic load_word(input cache_pkg::word_t addr, output logic quick);
    cache_pkg::word_t got;
    access(1'b0, addr, '0, got, quick);
    if (timeouts == 0) begin
      check_word("dmem_load", expected_load(addr), got);
    end
  endtask

  task automatic release_bus();
    @(negedge CLK);
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
  endtask

  task automatic flush_cache();
    int cycles;
    release_bus();
    halt = 1'b1;
    #1;
    cycles = 0;
    while (flushed !== 1'b1 && cycles < TIMEOUT_CYCLES) begin
      @(negedge CLK);
      #1;
      cycles++;
    end
    if (flushed !== 1'b1) begin
      timeouts++;
      $display("timeout: flushed did not rise within %0d cycles of halt", TIMEOUT_CYCLES);
    end else begin
      // held while halt stays up and gone one cycle after release
      @(negedge CLK);
      #1;
      check_bit("flushed", 1'b1, flushed);
      @(negedge CLK);
      halt = 1'b0;
      @(negedge CLK);
      #1;
      check_bit("flushed", 1'b0, flushed);
    end
  endtask

  task automatic end_test(input int num, input string title, input int errs_before);
    int errs;
    errs = errors + timeouts - errs_before;
    if (errs == 0) begin
      $display("test %0d %s: ok", num, title);
    end else begin
      $display("test %0d %s: FAILED with %0d errors", num, title, errs);
    end
  endtask

  initial begin : stimulus
    cache_pkg::word_t a;
    logic             quick;
    int               errs_before;
    nRST       = 1'b0;
    dmem_ren   = 1'b0;
    dmem_wen   = 1'b0;
    halt       = 1'b0;
    dmem_addr  = '0;
    dmem_store = '0;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    rng        = SEED;
    ref_mem    = '{default: '0};
    touched    = '{default: 1'b0};
    repeat (10) @(negedge CLK);
    nRST = 1'b1;

    errs_before = errors + timeouts;
    #1;
    check_bit("dhit", 1'b0, dhit);
    check_bit("flushed", 1'b0, flushed);
    load_word(make_addr(6, 4, 1), quick);
    end_test(1, "cold load", errs_before);

    // second access to a just filled block hits at once
    errs_before = errors + timeouts;
    a = make_addr(1, 1, 0);
    store_word(a, 32'hcafe_0001);
    load_word(a, quick);
    check_bit("dhit", 1'b1, quick);
    load_word(a | 32'h4, quick);
    check_bit("dhit", 1'b1, quick);
    end_test(2, "store then load", errs_before);

    // three tags in set 5 force a dirty victim out
    errs_before = errors + timeouts;
    store_word(make_addr(2, 5, 0), 32'h3300_0002);
    store_word(make_addr(6, 5, 0), 32'h3300_0006);
    store_word(make_addr(9, 5, 0), 32'h3300_0009);
    load_word(make_addr(2, 5, 0), quick);
    load_word(make_addr(6, 5, 0), quick);
    load_word(make_addr(9, 5, 0), quick);
    end_test(3, "eviction with writeback", errs_before);

    errs_before = errors + timeouts;
    for (int i = 0; i < RANDOM_OPS; i++) begin
      rng = xorshift32(rng);
      a   = make_addr(int'(rng[1:0]), int'(rng[4:2]), int'(rng[5]));
      if (rng[6]) begin
        rng = xorshift32(rng);
        store_word(a, rng);
      end else begin
        load_word(a, quick);
      end
    end
    end_test(4, "random traffic", errs_before);

    errs_before = errors + timeouts;
    for (int i = 0; i < 4; i++) begin
      rng = xorshift32(rng);
      a   = make_addr(4 + i, int'(rng[2:0]), int'(rng[3]));
      store_word(a, rng);
    end
    flush_cache();
    // last stored block sat dirty in the cache, so it must miss now
    load_word(a, quick);
    check_bit("dhit", 1'b0, quick);
    for (int i = 0; i < cache_pkg::MEM_WORDS; i++) begin
      a = cache_pkg::word_t'(i << 2);
      if (touched[a[AW+1:2]]) begin
        load_word(a, quick);
      end
    end
    end_test(5, "halt flush", errs_before);

    release_bus();
    $display("%0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- dcache_top.f
src/cache_pkg.sv
src/dcache.sv
src/main_mem.sv
src/dcache_top.sv
bench/tb_clock.sv
bench/dcache_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing
TOP      := dcache_tb
FLIST    := dcache_top.f
OBJ      := obj_dir
PASS_MSG := All checks passed

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)
	out="$$(./$(OBJ)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ)
